// File: bench/dram_traffic_sva.sv
`default_nettype none

module dram_traffic_sva (
    input wire                      clk_dram_ctrl,
    input wire                      rst_dram_ctrl,
    input wire                      o_mem_stb,
    input wire dram_pkg::mem_req_t  o_mem_req,
    input wire                      i_mem_stall,
    input wire                      o_audio_valid,
    input wire dram_pkg::mem_data_t o_audio_data,
    input wire                      i_audio_ready,
    input wire                      o_video_valid,
    input wire dram_pkg::mem_data_t o_video_data,
    input wire                      i_video_ready,
    input wire                      o_load_ready,
    input wire                      o_rd_ready
);
    int unsigned fail_count = 0;  // failed assertions so far

    // request frozen while the controller stalls
    assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_mem_stb && i_mem_stall |=> o_mem_stb && $stable(o_mem_req))
        else begin
            fail_count = fail_count + 1;
            $error("memory request changed under stall");
        end

    assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_audio_valid && !i_audio_ready |=> o_audio_valid && $stable(o_audio_data))
        else begin
            fail_count = fail_count + 1;
            $error("audio response dropped before ready");
        end

    assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_video_valid && !i_video_ready |=> o_video_valid && $stable(o_video_data))
        else begin
            fail_count = fail_count + 1;
            $error("video response dropped before ready");
        end

    // load and play phases never overlap
    assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        !(o_load_ready && o_rd_ready))
        else begin
            fail_count = fail_count + 1;
            $error("load ready and read ready high together");
        end

endmodule

bind dram_traffic_top dram_traffic_sva sva (
    .clk_dram_ctrl(clk_dram_ctrl),
    .rst_dram_ctrl(rst_dram_ctrl),
    .o_mem_stb    (o_mem_stb),
    .o_mem_req    (o_mem_req),
    .i_mem_stall  (i_mem_stall),
    .o_audio_valid(o_audio_valid),
    .o_audio_data (o_audio_data),
    .i_audio_ready(i_audio_ready),
    .o_video_valid(o_video_valid),
    .o_video_data (o_video_data),
    .i_video_ready(i_video_ready),
    .o_load_ready (o_load_ready),
    .o_rd_ready   (o_rd_ready)
);

`default_nettype wire

// File: bench/dram_traffic_tb.sv
`default_nettype none

module dram_traffic_tb;
    import dram_pkg::*;
    import stream_pkg::*;

    typedef struct packed {
        logic      is_read;
        mem_addr_t addr;
        dest_e     dest;
        logic      hold;    // audio consumer stalled while this entry is presented
    } step_t;

    localparam int N_LOADS = 8;
    localparam int N_STEPS = 20;
    localparam int LIMIT   = 40 * N_STEPS + 200;

    localparam step_t STEPS [N_STEPS] = '{
        '{1'b0, 24'd0, DEST_AUDIO, 1'b0},
        '{1'b0, 24'd1, DEST_AUDIO, 1'b0},
        '{1'b0, 24'd2, DEST_AUDIO, 1'b0},
        '{1'b0, 24'd3, DEST_AUDIO, 1'b0},
        '{1'b0, 24'd4, DEST_AUDIO, 1'b0},
        '{1'b0, 24'd5, DEST_AUDIO, 1'b0},
        '{1'b0, 24'd6, DEST_AUDIO, 1'b0},
        '{1'b0, 24'd7, DEST_AUDIO, 1'b0},  // marked last
        '{1'b1, 24'd3, DEST_AUDIO, 1'b0},
        '{1'b1, 24'd5, DEST_VIDEO, 1'b0},
        '{1'b1, 24'd0, DEST_VIDEO, 1'b0},
        '{1'b1, 24'd7, DEST_VIDEO, 1'b1},  // audio stalls from here
        '{1'b1, 24'd2, DEST_AUDIO, 1'b1},
        '{1'b1, 24'd6, DEST_VIDEO, 1'b1},
        '{1'b1, 24'd1, DEST_AUDIO, 1'b1},
        '{1'b1, 24'd4, DEST_AUDIO, 1'b1},
        '{1'b1, 24'd2, DEST_VIDEO, 1'b0},  // audio drains again
        '{1'b1, 24'd7, DEST_AUDIO, 1'b0},
        '{1'b1, 24'd0, DEST_AUDIO, 1'b0},
        '{1'b1, 24'd6, DEST_VIDEO, 1'b0}
    };

    logic        clk_dram_ctrl = 1'b0;
    logic        rst_dram_ctrl = 1'b1;
    logic        i_load_valid;
    load_beat_t  i_load_beat;
    logic        o_load_ready;
    logic        i_rd_valid;
    read_req_t   i_rd_req;
    logic        o_rd_ready;
    logic        o_audio_valid;
    mem_data_t   o_audio_data;
    logic        i_audio_ready;
    logic        o_video_valid;
    mem_data_t   o_video_data;
    logic        i_video_ready;
    logic        o_mem_stb;
    mem_req_t    o_mem_req;
    logic        i_mem_stall;
    logic        i_mem_ack;
    mem_data_t   i_mem_rdata;
    logic        o_load_complete;
    logic [15:0] o_complete_count;

    integer    seed = 32'h738d;
    int        cyc = 0;
    int        last_due = 0;
    int        wr_count = 0;
    int        acks_seen = 0;
    int        n_reads = 0;
    logic      ack_last = 1'b0;
    logic      done_exp = 1'b0;
    mem_data_t mem [256];
    int        pend_due [$];    // ack cycle per accepted request, in order
    mem_data_t pend_data [$];
    logic      pend_last [$];
    mem_addr_t rd_addr_q [$];
    mem_data_t exp_audio [$];
    mem_data_t exp_video [$];

    dram_traffic_top #(.RESP_DEPTH(4), .TAG_DEPTH(8)) DUT (.*);

    initial begin
        forever #2 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    // sample word for load index, every bit of the index shows up
    function automatic mem_data_t load_word(input int idx);
        logic [31:0] a;
        a = idx;
        return {a ^ 32'h5a5a_0f0f, a * 32'h0101_0101, ~a, 32'hc0de_0000 | a};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input mem_data_t exp, input mem_data_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // memory model, accept side
    always @(posedge clk_dram_ctrl) begin
        int due;
        cyc = cyc + 1;
        if (cyc > LIMIT) begin
            report_failure($sformatf("timeout: run still busy after %0d cycles", LIMIT));
        end
        if (!rst_dram_ctrl && i_mem_ack) begin
            acks_seen = acks_seen + 1;
        end
        if (!rst_dram_ctrl && o_mem_stb && !i_mem_stall) begin
            due = cyc + 1 + ($random(seed) & 3);  // ack 2..5 edges later
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            pend_due.push_back(due);
            if (o_mem_req.kind == REQ_WRITE) begin
                check_addr("load address", mem_addr_t'(wr_count), o_mem_req.addr);
                check_data("load data", load_word(wr_count), o_mem_req.wdata);
                mem[o_mem_req.addr[7:0]] = o_mem_req.wdata;
                wr_count = wr_count + 1;
                pend_data.push_back('0);
                pend_last.push_back(wr_count == N_LOADS);
            end else if (rd_addr_q.size() == 0) begin
                report_failure("memory saw a read that no request asked for");
            end else begin
                check_addr("read address", rd_addr_q.pop_front(), o_mem_req.addr);
                pend_data.push_back(mem[o_mem_req.addr[7:0]]);
                pend_last.push_back(1'b0);
            end
        end
    end

    // memory model, response side
    always @(negedge clk_dram_ctrl) begin
        i_mem_stall = (($random(seed) & 3) == 0);
        if (pend_due.size() != 0 && pend_due[0] <= cyc) begin
            pend_due.delete(0);
            i_mem_ack   = 1'b1;
            i_mem_rdata = pend_data.pop_front();
            ack_last    = pend_last.pop_front();
        end else begin
            i_mem_ack   = 1'b0;
            i_mem_rdata = '0;
            ack_last    = 1'b0;
        end
    end

    always @(posedge clk_dram_ctrl) begin
        if (!rst_dram_ctrl) begin
            check_bit("load complete", done_exp, o_load_complete);
            if (i_mem_ack && ack_last) begin
                done_exp = 1'b1;  // visible from the next edge
            end
            if (o_rd_ready && !o_load_complete) begin
                report_failure("read ready went high before the load completed");
            end
            if (o_load_ready && o_load_complete) begin
                report_failure("load ready went high after the load completed");
            end
            if (o_audio_valid && i_audio_ready) begin
                if (exp_audio.size() == 0) begin
                    report_failure("audio word delivered with no read outstanding");
                end else begin
                    check_data("audio word", exp_audio.pop_front(), o_audio_data);
                end
            end
            if (o_video_valid && i_video_ready) begin
                if (exp_video.size() == 0) begin
                    report_failure("video word delivered with no read outstanding");
                end else begin
                    check_data("video word", exp_video.pop_front(), o_video_data);
                end
            end
        end
    end

    initial begin
        i_load_valid  = 1'b0;
        i_load_beat   = '0;
        i_rd_valid    = 1'b0;
        i_rd_req      = '0;
        i_audio_ready = 1'b1;
        i_video_ready = 1'b1;
        i_mem_stall   = 1'b0;
        i_mem_ack     = 1'b0;
        i_mem_rdata   = '0;
        repeat (3) @(posedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        rst_dram_ctrl = 1'b0;
        check_bit("strobe after reset", 1'b0, o_mem_stb);
        check_count("count after reset", 16'd0, o_complete_count);

        for (int i = 0; i < N_STEPS; i++) begin
            @(negedge clk_dram_ctrl);
            i_audio_ready = !STEPS[i].hold;
            i_load_valid  = !STEPS[i].is_read;
            i_rd_valid    = STEPS[i].is_read;
            if (!STEPS[i].is_read) begin
                i_load_beat = '{data: load_word(int'(STEPS[i].addr)), last: (i == N_LOADS - 1)};
                do begin
                    @(posedge clk_dram_ctrl);
                end while (!o_load_ready);
            end else begin
                i_rd_req = '{addr: STEPS[i].addr, dest: STEPS[i].dest};
                do begin
                    @(posedge clk_dram_ctrl);
                end while (!o_rd_ready);
                n_reads = n_reads + 1;
                rd_addr_q.push_back(STEPS[i].addr);
                if (STEPS[i].dest == DEST_AUDIO) begin
                    exp_audio.push_back(load_word(int'(STEPS[i].addr)));
                end else begin
                    exp_video.push_back(load_word(int'(STEPS[i].addr)));
                end
            end
        end

        @(negedge clk_dram_ctrl);
        i_load_valid  = 1'b0;
        i_rd_valid    = 1'b0;
        i_audio_ready = 1'b1;
        // drain, the cycle counter catches a hang
        while (acks_seen != N_STEPS || exp_audio.size() != 0 || exp_video.size() != 0) begin
            @(negedge clk_dram_ctrl);
        end
        check_count("completion count", 16'(N_LOADS + n_reads), o_complete_count);
        if (DUT.sva.fail_count != 0) begin
            report_failure($sformatf("%0d bound assertion failures during the run",
                                     DUT.sva.fail_count));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: design/dram_pkg.sv
`default_nettype none

package dram_pkg;

    // burst address as seen by the controller port
    typedef logic [23:0]  mem_addr_t;
    typedef logic [127:0] mem_data_t;  // one burst, 8 x 16-bit lanes

    typedef enum logic [1:0] {
        REQ_WRITE = 2'd0,
        REQ_READ  = 2'd1
    } req_kind_e;

    // what travels on the strobe/stall/ack port
    typedef struct packed {
        req_kind_e kind;
        mem_addr_t addr;
        mem_data_t wdata;   // don't care for reads
    } mem_req_t;

    // issuer phases, sample load first then playback reads
    typedef enum logic {
        PHASE_LOAD = 1'b0,
        PHASE_PLAY = 1'b1
    } issue_phase_e;

endpackage

`default_nettype wire

// File: design/dram_traffic_top.sv
`default_nettype none

module dram_traffic_top #(
    parameter int RESP_DEPTH = 4,
    parameter int TAG_DEPTH  = 8
) (
    input  wire                          clk_dram_ctrl,
    input  wire                          rst_dram_ctrl,

    // sample load stream
    input  wire                          i_load_valid,
    input  wire stream_pkg::load_beat_t  i_load_beat,
    output logic                         o_load_ready,

    // read requests
    input  wire                          i_rd_valid,
    input  wire stream_pkg::read_req_t   i_rd_req,
    output logic                         o_rd_ready,

    output logic                         o_audio_valid,
    output dram_pkg::mem_data_t          o_audio_data,
    input  wire                          i_audio_ready,

    output logic                         o_video_valid,
    output dram_pkg::mem_data_t          o_video_data,
    input  wire                          i_video_ready,

    // controller port
    output logic                         o_mem_stb,
    output dram_pkg::mem_req_t           o_mem_req,
    input  wire                          i_mem_stall,
    input  wire                          i_mem_ack,
    input  wire dram_pkg::mem_data_t     i_mem_rdata,

    output logic                         o_load_complete,
    output logic [15:0]                  o_complete_count
);
    import dram_pkg::*;
    import stream_pkg::*;

    mem_tag_t    tag;
    logic        tag_push;
    logic        tag_full;
    logic        credit_audio;
    logic        credit_video;
    logic        load_done;
    logic        audio_push;
    logic        video_push;
    mem_data_t   resp_data;
    resp_slots_t audio_free;
    resp_slots_t video_free;

    mem_request_issuer issuer (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .rst_dram_ctrl  (rst_dram_ctrl),
        .i_load_valid   (i_load_valid),
        .i_load_beat    (i_load_beat),
        .o_load_ready   (o_load_ready),
        .i_rd_valid     (i_rd_valid),
        .i_rd_req       (i_rd_req),
        .o_rd_ready     (o_rd_ready),
        .i_load_done    (load_done),
        .i_tag_full     (tag_full),
        .i_credit_audio (credit_audio),
        .i_credit_video (credit_video),
        .o_mem_stb      (o_mem_stb),
        .o_mem_req      (o_mem_req),
        .i_mem_stall    (i_mem_stall),
        .o_tag_push     (tag_push),
        .o_tag          (tag),
        .o_load_complete(o_load_complete)
    );

    read_tag_queue #(
        .TAG_DEPTH(TAG_DEPTH)
    ) tag_q (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .rst_dram_ctrl  (rst_dram_ctrl),
        .i_tag_push     (tag_push),
        .i_tag          (tag),
        .o_tag_full     (tag_full),
        .i_mem_ack      (i_mem_ack),
        .i_mem_rdata    (i_mem_rdata),
        .o_audio_push   (audio_push),
        .o_video_push   (video_push),
        .o_resp_data    (resp_data),
        .i_audio_free   (audio_free),
        .i_video_free   (video_free),
        .o_credit_audio (credit_audio),
        .o_credit_video (credit_video),
        .o_load_done    (load_done)
    );

    resp_fifo #(
        .RESP_DEPTH(RESP_DEPTH)
    ) audio_q (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_push       (audio_push),
        .i_data       (resp_data),
        .o_valid      (o_audio_valid),
        .o_data       (o_audio_data),
        .i_ready      (i_audio_ready),
        .o_free       (audio_free)
    );

    resp_fifo #(
        .RESP_DEPTH(RESP_DEPTH)
    ) video_q (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_push       (video_push),
        .i_data       (resp_data),
        .o_valid      (o_video_valid),
        .o_data       (o_video_data),
        .i_ready      (i_video_ready),
        .o_free       (video_free)
    );

    // every ack, read or write, counts as one completed request
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_complete_count <= '0;
        end else if (i_mem_ack) begin
            o_complete_count <= o_complete_count + 1'b1;  // wraps at 16 bits
        end
    end

endmodule

`default_nettype wire

// File: design/mem_request_issuer.sv
`default_nettype none

module mem_request_issuer (
    input  wire                          clk_dram_ctrl,
    input  wire                          rst_dram_ctrl,

    input  wire                          i_load_valid,
    input  wire stream_pkg::load_beat_t  i_load_beat,
    output logic                         o_load_ready,

    input  wire                          i_rd_valid,
    input  wire stream_pkg::read_req_t   i_rd_req,
    output logic                         o_rd_ready,

    input  wire                          i_load_done,
    input  wire                          i_tag_full,
    input  wire                          i_credit_audio,
    input  wire                          i_credit_video,

    output logic                         o_mem_stb,
    output dram_pkg::mem_req_t           o_mem_req,
    input  wire                          i_mem_stall,

    output logic                         o_tag_push,
    output stream_pkg::mem_tag_t         o_tag,

    output logic                         o_load_complete
);
    import dram_pkg::*;
    import stream_pkg::*;

    issue_phase_e phase;
    logic         seen_last;    // last load beat already taken
    mem_addr_t    wr_addr;
    mem_tag_t     req_tag;

    logic accept;
    logic room;
    logic rd_credit;
    logic pend_same;
    logic take_load;
    logic take_rd;

    assign accept = o_mem_stb && !i_mem_stall;

    // register free now or freed this edge, and the tag queue can take one more
    assign room = (!o_mem_stb || accept) && !i_tag_full;

    always_comb begin
        case (i_rd_req.dest)
            DEST_AUDIO: rd_credit = i_credit_audio;
            default:    rd_credit = i_credit_video;
        endcase
    end

    // a read still sitting in the register is not counted by the tag queue yet,
    // so a second read to the same queue waits one cycle
    assign pend_same = o_mem_stb && (req_tag.kind == REQ_READ)
                       && (req_tag.dest == i_rd_req.dest);

    assign o_load_ready = (phase == PHASE_LOAD) && !seen_last && room;
    assign o_rd_ready   = (phase == PHASE_PLAY) && room && rd_credit && !pend_same;

    assign take_load = i_load_valid && o_load_ready;
    assign take_rd   = i_rd_valid && o_rd_ready;

    assign o_tag_push      = accept;
    assign o_tag           = req_tag;
    assign o_load_complete = (phase == PHASE_PLAY);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            phase     <= PHASE_LOAD;
            seen_last <= 1'b0;
            wr_addr   <= '0;
            o_mem_stb <= 1'b0;
        end else begin
            case (phase)
                PHASE_LOAD: begin
                    if (i_load_done) begin
                        phase <= PHASE_PLAY;  // last write acked
                    end
                end
                default: phase <= phase;
            endcase

            if (take_load) begin
                wr_addr <= wr_addr + 1'b1;  // sequential bursts from zero
                if (i_load_beat.last) begin
                    seen_last <= 1'b1;
                end
            end

            if (take_load || take_rd) begin
                o_mem_stb <= 1'b1;
            end else if (accept) begin
                o_mem_stb <= 1'b0;
            end
        end
    end

    // request payload, only changes when a new beat is taken
    always_ff @(posedge clk_dram_ctrl) begin
        if (take_load) begin
            o_mem_req <= '{kind: REQ_WRITE, addr: wr_addr, wdata: i_load_beat.data};
            req_tag   <= '{kind: REQ_WRITE, dest: DEST_AUDIO, last: i_load_beat.last};
        end else if (take_rd) begin
            o_mem_req <= '{kind: REQ_READ, addr: i_rd_req.addr, wdata: '0};
            req_tag   <= '{kind: REQ_READ, dest: i_rd_req.dest, last: 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: design/read_tag_queue.sv
`default_nettype none

module read_tag_queue #(
    parameter int TAG_DEPTH = 8
) (
    input  wire                          clk_dram_ctrl,
    input  wire                          rst_dram_ctrl,

    input  wire                          i_tag_push,
    input  wire stream_pkg::mem_tag_t    i_tag,
    output logic                         o_tag_full,

    input  wire                          i_mem_ack,
    input  wire dram_pkg::mem_data_t     i_mem_rdata,

    output logic                         o_audio_push,
    output logic                         o_video_push,
    output dram_pkg::mem_data_t          o_resp_data,

    input  wire stream_pkg::resp_slots_t i_audio_free,
    input  wire stream_pkg::resp_slots_t i_video_free,
    output logic                         o_credit_audio,
    output logic                         o_credit_video,

    output logic                         o_load_done
);
    import dram_pkg::*;
    import stream_pkg::*;

    localparam int PTR_W = $clog2(TAG_DEPTH);
    localparam int CNT_W = $clog2(TAG_DEPTH + 1);

    mem_tag_t         tags [TAG_DEPTH];
    mem_tag_t         head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    resp_slots_t      rd_audio;  // reads in flight per destination
    resp_slots_t      rd_video;
    logic             issue_audio;
    logic             issue_video;

    assign head = tags[rd_ptr];

    // responses come back in order, so the head tag names this ack
    assign o_resp_data  = i_mem_rdata;
    assign o_audio_push = i_mem_ack && (head.kind == REQ_READ) && (head.dest == DEST_AUDIO);
    assign o_video_push = i_mem_ack && (head.kind == REQ_READ) && (head.dest == DEST_VIDEO);
    assign o_load_done  = i_mem_ack && (head.kind == REQ_WRITE) && head.last;

    // one slot held back for the request parked in the issuer
    assign o_tag_full = (count >= CNT_W'(TAG_DEPTH - 1));

    assign issue_audio = i_tag_push && (i_tag.kind == REQ_READ) && (i_tag.dest == DEST_AUDIO);
    assign issue_video = i_tag_push && (i_tag.kind == REQ_READ) && (i_tag.dest == DEST_VIDEO);

    assign o_credit_audio = (i_audio_free > rd_audio);
    assign o_credit_video = (i_video_free > rd_video);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_audio <= '0;
            rd_video <= '0;
        end else begin
            if (i_tag_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_mem_ack) begin
                rd_ptr <= (rd_ptr == PTR_W'(TAG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_tag_push, i_mem_ack})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            rd_audio <= rd_audio + resp_slots_t'(issue_audio) - resp_slots_t'(o_audio_push);
            rd_video <= rd_video + resp_slots_t'(issue_video) - resp_slots_t'(o_video_push);
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (i_tag_push) begin
            tags[wr_ptr] <= i_tag;
        end
    end

endmodule

`default_nettype wire

// File: design/resp_fifo.sv
`default_nettype none

module resp_fifo #(
    parameter int RESP_DEPTH = 4
) (
    input  wire                          clk_dram_ctrl,
    input  wire                          rst_dram_ctrl,

    input  wire                          i_push,
    input  wire dram_pkg::mem_data_t     i_data,

    output logic                         o_valid,
    output dram_pkg::mem_data_t          o_data,
    input  wire                          i_ready,

    output stream_pkg::resp_slots_t      o_free
);
    import dram_pkg::*;
    import stream_pkg::*;

    localparam int PTR_W = $clog2(RESP_DEPTH);

    mem_data_t        words [RESP_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    resp_slots_t      count;
    logic             pop;

    assign pop     = o_valid && i_ready;
    assign o_valid = (count != '0);
    assign o_data  = words[rd_ptr];
    assign o_free  = resp_slots_t'(RESP_DEPTH) - count;  // room left for the tag queue

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (i_push) begin
            words[wr_ptr] <= i_data;
        end
    end

endmodule

`default_nettype wire

// File: design/stream_pkg.sv
`default_nettype none

package stream_pkg;

    typedef enum logic {
        DEST_AUDIO = 1'b0,
        DEST_VIDEO = 1'b1
    } dest_e;

    // sample load beat, last marks the final word of the load
    typedef struct packed {
        dram_pkg::mem_data_t data;
        logic                last;
    } load_beat_t;

    typedef struct packed {
        dram_pkg::mem_addr_t addr;
        dest_e               dest;
    } read_req_t;

    // one entry per request in flight at the memory
    typedef struct packed {
        dram_pkg::req_kind_e kind;
        dest_e               dest;   // only meaningful for reads
        logic                last;   // only meaningful for writes
    } mem_tag_t;

    // free slots in a response queue and reads owed to it
    typedef logic [7:0] resp_slots_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dram_traffic_tb \
    -f sim.f -o dram_traffic_sim \
    && ./obj_dir/dram_traffic_sim | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
design/dram_pkg.sv
design/stream_pkg.sv
design/mem_request_issuer.sv
design/read_tag_queue.sv
design/resp_fifo.sv
design/dram_traffic_top.sv
bench/dram_traffic_sva.sv
bench/dram_traffic_tb.sv
